/* cluster_periph_pkg.sv */
/*
  Shared widths, register map and metric encoding of the cluster peripheral.
  The address map is sized for MAX_COUNTERS; a design must not exceed it.
*/
package cluster_periph_pkg;

  typedef logic [7:0]  addr_t;
  typedef logic [31:0] data_t;
  // Counter value, read as a low word and a zero-extended high word.
  typedef logic [47:0] cnt_t;

  localparam int unsigned METRIC_W = 5;
  localparam int unsigned HART_W   = 4;
  localparam int unsigned SEL_HART_LSB = 8;

  typedef enum logic [METRIC_W-1:0] {
    CYCLE          = 5'd0,
    RETIRED_INSTR  = 5'd1,
    RETIRED_LOAD   = 5'd2,
    ISSUE_FPU      = 5'd3,
    TCDM_ACCESSED  = 5'd4,
    TCDM_CONGESTED = 5'd5,
    DMA_BUSY       = 5'd6,
    DMA_AW_DONE    = 5'd7,
    DMA_AW_BW      = 5'd8,
    NONE           = 5'd31
  } metric_e;

  // Per-core events.
  typedef logic [2:0] core_ev_t;
  localparam int unsigned CORE_EV_RETIRED_INSTR = 0;
  localparam int unsigned CORE_EV_RETIRED_LOAD  = 1;
  localparam int unsigned CORE_EV_ISSUE_FPU     = 2;

  // Shared data memory events.
  typedef logic [1:0] tcdm_ev_t;
  localparam int unsigned TCDM_EV_ACCESSED  = 0;
  localparam int unsigned TCDM_EV_CONGESTED = 1;

  // DMA events: busy, aw_done, aw_len and aw_size.
  typedef logic [11:0] dma_ev_t;
  localparam int unsigned DMA_EV_BUSY     = 11;
  localparam int unsigned DMA_EV_AW_DONE  = 10;
  localparam int unsigned DMA_EV_LEN_LSB  = 2;
  localparam int unsigned DMA_EV_LEN_W    = 8;
  localparam int unsigned DMA_EV_SIZE_LSB = 0;
  localparam int unsigned DMA_EV_SIZE_W   = 2;

  localparam int unsigned MAX_COUNTERS = 8;

  // Register map: 0x00, 0x20, 0x40, 0x80, 0x84 and 0x88.
  localparam addr_t ADDR_CNT_EN_BASE = 8'h00;
  localparam addr_t ADDR_SEL_BASE    = addr_t'(ADDR_CNT_EN_BASE + 4 * MAX_COUNTERS);
  localparam addr_t ADDR_CNT_BASE    = addr_t'(ADDR_SEL_BASE + 4 * MAX_COUNTERS);
  localparam addr_t ADDR_CLINT_SET   = addr_t'(ADDR_CNT_BASE + 8 * MAX_COUNTERS);
  localparam addr_t ADDR_CLINT_CLEAR = addr_t'(ADDR_CLINT_SET + 4);
  localparam addr_t ADDR_PREFETCH    = addr_t'(ADDR_CLINT_CLEAR + 4);

  // Metrics tracked right after reset.
  localparam int unsigned NR_RST_METRICS = 4;
  localparam metric_e RST_METRICS [NR_RST_METRICS] = '{
    CYCLE,
    RETIRED_INSTR,
    TCDM_ACCESSED,
    DMA_BUSY
  };

  // Counters beyond the table count cycles.
  function automatic metric_e rst_metric(input int unsigned idx);
    if (idx < NR_RST_METRICS) begin
      return RST_METRICS[idx];
    end
    return CYCLE;
  endfunction

endpackage

/* cluster_periph_if.sv */
/*
  Decoded write strobes and write data from the register decoder.
  Strobes are single-cycle levels that follow the bus request.
*/
`timescale 1ns/1ps

interface cluster_periph_if #(
  parameter int unsigned NR_COUNTERS = 4
);

  logic [NR_COUNTERS-1:0] sel_we;
  logic [NR_COUNTERS-1:0] cnt_we;
  logic [NR_COUNTERS-1:0] en_we;
  logic                   clint_set_we;
  logic                   clint_clr_we;
  logic                   prefetch_we;
  cluster_periph_pkg::data_t wdata;

  modport decoder (
    output sel_we,
    output cnt_we,
    output en_we,
    output clint_set_we,
    output clint_clr_we,
    output prefetch_we,
    output wdata
  );

  modport sink (
    input sel_we,
    input cnt_we,
    input en_we,
    input clint_set_we,
    input clint_clr_we,
    input prefetch_we,
    input wdata
  );

endinterface

/* event_sample.sv */
/*
  One register stage on the memory and DMA events.
  Counters see these events one cycle late.
*/
`timescale 1ns/1ps

module event_sample (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  cluster_periph_pkg::tcdm_ev_t tcdm_ev_i,
  input  cluster_periph_pkg::dma_ev_t  dma_ev_i,
  output cluster_periph_pkg::tcdm_ev_t tcdm_ev_o,
  output cluster_periph_pkg::dma_ev_t  dma_ev_o
);

  cluster_periph_pkg::tcdm_ev_t tcdm_ev_q;
  cluster_periph_pkg::dma_ev_t  dma_ev_q;

  // These events come from far across the cluster.
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      tcdm_ev_q <= '0;
      dma_ev_q  <= '0;
    end else begin
      tcdm_ev_q <= tcdm_ev_i;
      dma_ev_q  <= dma_ev_i;
    end
  end

  assign tcdm_ev_o = tcdm_ev_q;
  assign dma_ev_o  = dma_ev_q;

endmodule

/* reg_decode.sv */
/*
  Register bus decoder. Writes act at the next edge, reads are combinational.
  Address bits 1:0 are ignored; unmapped words read zero and drop writes.
  NR_COUNTERS must not exceed MAX_COUNTERS.
*/
`timescale 1ns/1ps

module reg_decode #(
  parameter int unsigned NR_COUNTERS = 4
) (
  input  logic                        req_i,
  input  logic                        we_i,
  input  cluster_periph_pkg::addr_t   addr_i,
  input  cluster_periph_pkg::data_t   wdata_i,
  output cluster_periph_pkg::data_t   rdata_o,
  cluster_periph_if.decoder           bus,
  input  cluster_periph_pkg::cnt_t    [NR_COUNTERS-1:0] cnt_val_i,
  input  cluster_periph_pkg::data_t   [NR_COUNTERS-1:0] sel_val_i,
  input  logic                        [NR_COUNTERS-1:0] en_val_i,
  input  cluster_periph_pkg::data_t   irq_i,
  input  logic                        prefetch_i
);

  logic                      wr;
  logic                      rd;
  cluster_periph_pkg::addr_t word_addr;
  cluster_periph_pkg::addr_t pair_addr;
  logic [NR_COUNTERS-1:0]    en_hit;
  logic [NR_COUNTERS-1:0]    sel_hit;
  logic [NR_COUNTERS-1:0]    cnt_hit;
  logic                      clint_set_hit;
  logic                      clint_clr_hit;
  logic                      prefetch_hit;

  assign wr = req_i & we_i;
  assign rd = req_i & ~we_i;

  assign word_addr = {addr_i[7:2], 2'b00};
  // Each counter value spans two words.
  assign pair_addr = {addr_i[7:3], 3'b000};

  always_comb begin
    for (int unsigned i = 0; i < NR_COUNTERS; i++) begin
      en_hit[i]  = word_addr == cluster_periph_pkg::addr_t'(
                   cluster_periph_pkg::ADDR_CNT_EN_BASE + 4 * i);
      sel_hit[i] = word_addr == cluster_periph_pkg::addr_t'(
                   cluster_periph_pkg::ADDR_SEL_BASE + 4 * i);
      cnt_hit[i] = pair_addr == cluster_periph_pkg::addr_t'(
                   cluster_periph_pkg::ADDR_CNT_BASE + 8 * i);
    end
  end

  assign clint_set_hit = word_addr == cluster_periph_pkg::ADDR_CLINT_SET;
  assign clint_clr_hit = word_addr == cluster_periph_pkg::ADDR_CLINT_CLEAR;
  assign prefetch_hit  = word_addr == cluster_periph_pkg::ADDR_PREFETCH;

  // Write strobes.
  assign bus.en_we        = {NR_COUNTERS{wr}} & en_hit;
  assign bus.sel_we       = {NR_COUNTERS{wr}} & sel_hit;
  assign bus.cnt_we       = {NR_COUNTERS{wr}} & cnt_hit;
  assign bus.clint_set_we = wr & clint_set_hit;
  assign bus.clint_clr_we = wr & clint_clr_hit;
  assign bus.prefetch_we  = wr & prefetch_hit;
  assign bus.wdata        = wdata_i;

  // Read mux.
  always_comb begin
    rdata_o = '0;
    if (rd) begin
      for (int unsigned i = 0; i < NR_COUNTERS; i++) begin
        if (en_hit[i]) begin
          rdata_o = cluster_periph_pkg::data_t'(en_val_i[i]);
        end
        if (sel_hit[i]) begin
          rdata_o = sel_val_i[i];
        end
        if (cnt_hit[i]) begin
          // High word carries bits 47:32, zero-extended.
          rdata_o = addr_i[2] ? cluster_periph_pkg::data_t'(cnt_val_i[i][47:32])
                              : cnt_val_i[i][31:0];
        end
      end
      if (clint_set_hit || clint_clr_hit) begin
        rdata_o = irq_i;
      end
      if (prefetch_hit) begin
        rdata_o = cluster_periph_pkg::data_t'(prefetch_i);
      end
    end
  end

endmodule

/* perf_counter.sv */
/*
  One 48-bit performance counter with metric and hart select.
  Memory and DMA events are cluster-wide and ignore the hart select.
  A hart select at or above NR_CORES counts no core events.
*/
`timescale 1ns/1ps

module perf_counter #(
  parameter int unsigned NR_CORES = 4,
  parameter int unsigned IDX      = 0
) (
  input  logic                                         clk_i,
  input  logic                                         rst_n_i,
  input  cluster_periph_pkg::core_ev_t [NR_CORES-1:0]  core_ev_i,
  input  cluster_periph_pkg::tcdm_ev_t                 tcdm_ev_i,
  input  cluster_periph_pkg::dma_ev_t                  dma_ev_i,
  input  logic                                         sel_we_i,
  input  logic                                         cnt_we_i,
  input  logic                                         en_we_i,
  input  cluster_periph_pkg::data_t                    wdata_i,
  output cluster_periph_pkg::cnt_t                     cnt_o,
  output cluster_periph_pkg::data_t                    sel_o,
  output logic                                         en_o
);

  localparam cluster_periph_pkg::metric_e RST_METRIC = cluster_periph_pkg::rst_metric(IDX);
  localparam int unsigned HART_W = cluster_periph_pkg::HART_W;

  cluster_periph_pkg::metric_e  metric_q;
  logic [HART_W-1:0]            hart_q;
  logic                         en_q;
  cluster_periph_pkg::cnt_t     cnt_q;
  cluster_periph_pkg::core_ev_t core_sel;
  cluster_periph_pkg::cnt_t     aw_bytes;
  cluster_periph_pkg::cnt_t     inc;

  assign core_sel = (hart_q < NR_CORES) ? core_ev_i[hart_q] : '0;

  // Burst bytes are (len + 1) beats of 2**size bytes.
  assign aw_bytes = (cluster_periph_pkg::cnt_t'(
                      dma_ev_i[cluster_periph_pkg::DMA_EV_LEN_LSB +:
                               cluster_periph_pkg::DMA_EV_LEN_W]) + 48'd1)
                    << dma_ev_i[cluster_periph_pkg::DMA_EV_SIZE_LSB +:
                                cluster_periph_pkg::DMA_EV_SIZE_W];

  always_comb begin
    inc = '0;
    case (metric_q)
      cluster_periph_pkg::CYCLE:
        inc = 48'd1;
      cluster_periph_pkg::RETIRED_INSTR:
        inc = 48'(core_sel[cluster_periph_pkg::CORE_EV_RETIRED_INSTR]);
      cluster_periph_pkg::RETIRED_LOAD:
        inc = 48'(core_sel[cluster_periph_pkg::CORE_EV_RETIRED_LOAD]);
      cluster_periph_pkg::ISSUE_FPU:
        inc = 48'(core_sel[cluster_periph_pkg::CORE_EV_ISSUE_FPU]);
      cluster_periph_pkg::TCDM_ACCESSED:
        inc = 48'(tcdm_ev_i[cluster_periph_pkg::TCDM_EV_ACCESSED]);
      cluster_periph_pkg::TCDM_CONGESTED:
        inc = 48'(tcdm_ev_i[cluster_periph_pkg::TCDM_EV_CONGESTED]);
      cluster_periph_pkg::DMA_BUSY:
        inc = 48'(dma_ev_i[cluster_periph_pkg::DMA_EV_BUSY]);
      cluster_periph_pkg::DMA_AW_DONE:
        inc = 48'(dma_ev_i[cluster_periph_pkg::DMA_EV_AW_DONE]);
      cluster_periph_pkg::DMA_AW_BW: begin
        // Bytes only count when the write burst completes.
        if (dma_ev_i[cluster_periph_pkg::DMA_EV_AW_DONE]) begin
          inc = aw_bytes;
        end
      end
      default:
        inc = '0;
    endcase
  end

  // Selection and enable registers.
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      metric_q <= RST_METRIC;
      hart_q   <= '0;
      en_q     <= 1'b1;
    end else begin
      if (sel_we_i) begin
        metric_q <= cluster_periph_pkg::metric_e'(
                      wdata_i[cluster_periph_pkg::METRIC_W-1:0]);
        hart_q   <= wdata_i[cluster_periph_pkg::SEL_HART_LSB +: HART_W];
      end
      if (en_we_i) begin
        en_q <= wdata_i[0];
      end
    end
  end

  // A write clears the count, only while enabled.
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (en_q) begin
      if (cnt_we_i) begin
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_q + inc;
      end
    end
  end

  assign cnt_o = cnt_q;
  assign sel_o = {20'd0, hart_q, 3'd0, metric_q};
  assign en_o  = en_q;

endmodule

/* wakeup_ctrl.sv */
/*
  Cluster wake-up bits with set and clear writes, and the prefetch enable.
  Set wins over clear; only the low NR_CORES data bits are used.
*/
`timescale 1ns/1ps

module wakeup_ctrl #(
  parameter int unsigned NR_CORES = 4
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  cluster_periph_if.sink      bus,
  output logic [NR_CORES-1:0] irq_o,
  output logic                prefetch_en_o
);

  logic [NR_CORES-1:0] irq_q;
  logic                prefetch_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      irq_q      <= '0;
      prefetch_q <= 1'b1;
    end else begin
      if (bus.clint_set_we) begin
        irq_q <= irq_q | bus.wdata[NR_CORES-1:0];
      end else if (bus.clint_clr_we) begin
        irq_q <= irq_q & ~bus.wdata[NR_CORES-1:0];
      end
      if (bus.prefetch_we) begin
        prefetch_q <= bus.wdata[0];
      end
    end
  end

  assign irq_o         = irq_q;
  assign prefetch_en_o = prefetch_q;

endmodule

/* cluster_periph.sv */
/*
  Cluster peripheral top: performance counters, wake-up and prefetch enable.
  Reads are combinational; there is no back-pressure on the bus.
  NR_COUNTERS must not exceed MAX_COUNTERS.
*/
`timescale 1ns/1ps

module cluster_periph #(
  parameter int unsigned NR_CORES    = 4,
  parameter int unsigned NR_COUNTERS = 4
) (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,
  input  logic                                        req_i,
  input  logic                                        we_i,
  input  cluster_periph_pkg::addr_t                   addr_i,
  input  cluster_periph_pkg::data_t                   wdata_i,
  output cluster_periph_pkg::data_t                   rdata_o,
  input  cluster_periph_pkg::core_ev_t [NR_CORES-1:0] core_ev_i,
  input  cluster_periph_pkg::tcdm_ev_t                tcdm_ev_i,
  input  cluster_periph_pkg::dma_ev_t                 dma_ev_i,
  output logic [NR_CORES-1:0]                         irq_o,
  output logic                                        prefetch_en_o
);

  cluster_periph_pkg::tcdm_ev_t                  tcdm_ev_q;
  cluster_periph_pkg::dma_ev_t                   dma_ev_q;
  cluster_periph_pkg::cnt_t  [NR_COUNTERS-1:0]   cnt_val;
  cluster_periph_pkg::data_t [NR_COUNTERS-1:0]   sel_val;
  logic                      [NR_COUNTERS-1:0]   en_val;

  cluster_periph_if #(.NR_COUNTERS(NR_COUNTERS)) bus ();

  event_sample i_event_sample (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .tcdm_ev_i (tcdm_ev_i),
    .dma_ev_i  (dma_ev_i),
    .tcdm_ev_o (tcdm_ev_q),
    .dma_ev_o  (dma_ev_q)
  );

  reg_decode #(
    .NR_COUNTERS (NR_COUNTERS)
  ) i_reg_decode (
    .req_i      (req_i),
    .we_i       (we_i),
    .addr_i     (addr_i),
    .wdata_i    (wdata_i),
    .rdata_o    (rdata_o),
    .bus        (bus),
    .cnt_val_i  (cnt_val),
    .sel_val_i  (sel_val),
    .en_val_i   (en_val),
    .irq_i      (cluster_periph_pkg::data_t'(irq_o)),
    .prefetch_i (prefetch_en_o)
  );

  for (genvar i = 0; i < NR_COUNTERS; i++) begin : gen_cnt
    perf_counter #(
      .NR_CORES (NR_CORES),
      .IDX      (i)
    ) i_perf_counter (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .core_ev_i (core_ev_i),
      .tcdm_ev_i (tcdm_ev_q),
      .dma_ev_i  (dma_ev_q),
      .sel_we_i  (bus.sel_we[i]),
      .cnt_we_i  (bus.cnt_we[i]),
      .en_we_i   (bus.en_we[i]),
      .wdata_i   (bus.wdata),
      .cnt_o     (cnt_val[i]),
      .sel_o     (sel_val[i]),
      .en_o      (en_val[i])
    );
  end

  wakeup_ctrl #(
    .NR_CORES (NR_CORES)
  ) i_wakeup_ctrl (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .bus           (bus),
    .irq_o         (irq_o),
    .prefetch_en_o (prefetch_en_o)
  );

endmodule

/* tb_cluster_periph.sv */
/*
  Testbench for the cluster peripheral with 4 cores and 4 counters.
  Keeps its own model of every counter; events come from a seeded LCG.
*/
`timescale 1ns/1ps

module tb_cluster_periph;

  localparam int NR_CORES       = 4;
  localparam int NR_COUNTERS    = 4;
  localparam int TIMEOUT_CYCLES = 5000;
  localparam int NR_OPS         = 28;

  typedef struct packed {
    logic        we;
    logic [7:0]  addr;
    logic [31:0] data;
  } bus_op_t;

  // Static register accesses. On reads, data is the expected read value.
  localparam bus_op_t OPS [NR_OPS] = '{
    '{1'b0, 8'h20, 32'h0}, '{1'b0, 8'h24, 32'h1}, '{1'b0, 8'h28, 32'h4},
    '{1'b0, 8'h2C, 32'h6}, '{1'b0, 8'h00, 32'h1}, '{1'b0, 8'h04, 32'h1},
    '{1'b0, 8'h08, 32'h1}, '{1'b0, 8'h0C, 32'h1}, '{1'b0, 8'h10, 32'h0},
    '{1'b0, 8'h30, 32'h0}, '{1'b0, 8'h60, 32'h0}, '{1'b0, 8'h8C, 32'h0},
    '{1'b0, 8'hFC, 32'h0}, '{1'b0, 8'h80, 32'h0}, '{1'b0, 8'h88, 32'h1},
    '{1'b1, 8'h80, 32'h5}, '{1'b0, 8'h84, 32'h5}, '{1'b1, 8'h80, 32'h2},
    '{1'b0, 8'h80, 32'h7}, '{1'b1, 8'h84, 32'h4}, '{1'b0, 8'h80, 32'h3},
    '{1'b1, 8'h84, 32'hF}, '{1'b0, 8'h84, 32'h0}, '{1'b1, 8'h80, 32'h8},
    '{1'b1, 8'h8C, 32'hF}, '{1'b0, 8'h8C, 32'h0}, '{1'b1, 8'h88, 32'h0},
    '{1'b0, 8'h88, 32'h0}
  };

  // Metrics of counters 0 to 3 after reset.
  localparam logic [4:0] RESET_METRIC [4] = '{5'd0, 5'd1, 5'd4, 5'd6};

  logic                       clk_i;
  logic                       rst_n_i;
  logic                       req_i;
  logic                       we_i;
  logic [7:0]                 addr_i;
  logic [31:0]                wdata_i;
  logic [31:0]                rdata_o;
  logic [NR_CORES-1:0][2:0]   core_ev_i;
  logic [1:0]                 tcdm_ev_i;
  logic [11:0]                dma_ev_i;
  logic [NR_CORES-1:0]        irq_o;
  logic                       prefetch_en_o;

  logic [47:0] m_cnt [NR_COUNTERS];
  logic [4:0]  m_metric [NR_COUNTERS];
  logic [3:0]  m_hart [NR_COUNTERS];
  logic        m_en [NR_COUNTERS];
  logic [1:0]  m_tcdm_q;
  logic [11:0] m_dma_q;
  logic [31:0] cycles0;
  logic [31:0] lcg_state = 32'd2;
  logic        ev_on;

  cluster_periph #(
    .NR_CORES    (NR_CORES),
    .NR_COUNTERS (NR_COUNTERS)
  ) i_cluster_periph (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .req_i         (req_i),
    .we_i          (we_i),
    .addr_i        (addr_i),
    .wdata_i       (wdata_i),
    .rdata_o       (rdata_o),
    .core_ev_i     (core_ev_i),
    .tcdm_ev_i     (tcdm_ev_i),
    .dma_ev_i      (dma_ev_i),
    .irq_o         (irq_o),
    .prefetch_en_o (prefetch_en_o)
  );

  always #50 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic write_hit(input logic [7:0] base, input logic [7:0] mask);
    return req_i && we_i && ((addr_i & ~mask) == base);
  endfunction

  // Increment for one edge. Memory and DMA events are the sampled copies.
  function automatic logic [47:0] event_inc(input logic [4:0] metric, input logic [3:0] hart);
    logic [2:0] core;
    core = (hart < NR_CORES) ? core_ev_i[hart] : 3'b000;
    case (metric)
      5'd0: return 48'd1;
      5'd1: return 48'(core[0]);
      5'd2: return 48'(core[1]);
      5'd3: return 48'(core[2]);
      5'd4: return 48'(m_tcdm_q[0]);
      5'd5: return 48'(m_tcdm_q[1]);
      5'd6: return 48'(m_dma_q[11]);
      5'd7: return 48'(m_dma_q[10]);
      5'd8: return m_dma_q[10] ? (48'(m_dma_q[9:2]) + 48'd1) << m_dma_q[1:0] : 48'd0;
      default: return 48'd0;
    endcase
  endfunction

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("Some tests failed");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  // Advance one rising edge. Update the model with what the DUT sees, then drive new events.
  task automatic step();
    logic [31:0] r;
    @(posedge clk_i);
    for (int c = 0; c < NR_COUNTERS; c++) begin
      if (m_en[c]) begin
        if (write_hit(8'(cluster_periph_pkg::ADDR_CNT_BASE + 8 * c), 8'h07)) begin
          m_cnt[c] = '0;
        end else begin
          m_cnt[c] = m_cnt[c] + event_inc(m_metric[c], m_hart[c]);
        end
      end
      if (write_hit(8'(cluster_periph_pkg::ADDR_SEL_BASE + 4 * c), 8'h03)) begin
        m_metric[c] = wdata_i[4:0];
        m_hart[c]   = wdata_i[11:8];
      end
      if (write_hit(8'(cluster_periph_pkg::ADDR_CNT_EN_BASE + 4 * c), 8'h03)) begin
        m_en[c] = wdata_i[0];
      end
    end
    cycles0 = write_hit(cluster_periph_pkg::ADDR_CNT_BASE, 8'h07) ? 32'd0 : cycles0 + 1;
    m_tcdm_q = tcdm_ev_i;
    m_dma_q  = dma_ev_i;
    if (ev_on) begin
      r = lcg_next();
      core_ev_i <= r[27:16];
      tcdm_ev_i <= r[29:28];
      r = lcg_next();
      dma_ev_i  <= r[27:16];
    end else begin
      core_ev_i <= '0;
      tcdm_ev_i <= '0;
      dma_ev_i  <= '0;
    end
  endtask

  task automatic run(input int n);
    for (int i = 0; i < n; i++) begin
      step();
      req_i <= 1'b0;
      we_i  <= 1'b0;
    end
  endtask

  task automatic bus_write(input logic [7:0] a, input logic [31:0] d);
    step();
    req_i   <= 1'b1;
    we_i    <= 1'b1;
    addr_i  <= a;
    wdata_i <= d;
    @(negedge clk_i);
  endtask

  // Read data is sampled in the request cycle.
  task automatic bus_read(input logic [7:0] a, output logic [31:0] d);
    step();
    req_i   <= 1'b1;
    we_i    <= 1'b0;
    addr_i  <= a;
    wdata_i <= '0;
    @(negedge clk_i);
    d = rdata_o;
  endtask

  task automatic check_counter(input int c);
    logic [7:0]  a;
    logic [31:0] lo;
    logic [31:0] hi;
    a = 8'(cluster_periph_pkg::ADDR_CNT_BASE + 8 * c);
    bus_read(a, lo);
    check($sformatf("rdata_o (counter %0d low)", c), lo, m_cnt[c][31:0]);
    bus_read(a + 8'd4, hi);
    check($sformatf("rdata_o (counter %0d high)", c), hi, {16'd0, m_cnt[c][47:32]});
  endtask

  initial begin
    for (int i = 0; i < TIMEOUT_CYCLES; i++) begin
      @(posedge clk_i);
    end
    $display("Timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Some tests failed");
    $fatal(1, "Timeout");
  end

  initial begin
    logic [31:0] rd;
    logic [31:0] held;
    clk_i     = 1'b0;
    rst_n_i   = 1'b0;
    req_i     = 1'b0;
    we_i      = 1'b0;
    addr_i    = '0;
    wdata_i   = '0;
    core_ev_i = '0;
    tcdm_ev_i = '0;
    dma_ev_i  = '0;
    ev_on     = 1'b0;
    for (int i = 0; i < 8; i++) begin
      @(posedge clk_i);
    end
    rst_n_i <= 1'b1;
    for (int c = 0; c < NR_COUNTERS; c++) begin
      m_cnt[c]    = '0;
      m_metric[c] = (c < 4) ? RESET_METRIC[c] : 5'd0;
      m_hart[c]   = '0;
      m_en[c]     = 1'b1;
    end
    m_tcdm_q = '0;
    m_dma_q  = '0;
    cycles0  = '0;
    @(negedge clk_i);
    check("irq_o", irq_o, 0);
    check("prefetch_en_o", prefetch_en_o, 1);

    // Reset values, wake-up set and clear, and prefetch enable.
    for (int i = 0; i < NR_OPS; i++) begin
      if (OPS[i].we) begin
        bus_write(OPS[i].addr, OPS[i].data);
      end else begin
        bus_read(OPS[i].addr, rd);
        check($sformatf("rdata_o @0x%02h", OPS[i].addr), rd, OPS[i].data);
      end
    end
    check("irq_o", irq_o, 4'h8);
    check("prefetch_en_o", prefetch_en_o, 0);

    // Random event counting.
    ev_on = 1'b1;
    run(200);
    bus_read(cluster_periph_pkg::ADDR_CNT_BASE, rd);
    check("rdata_o (counter 0 vs elapsed cycles)", rd, cycles0);
    for (int c = 0; c < NR_COUNTERS; c++) begin
      check_counter(c);
    end

    // Retired loads of hart 2 on counter 1 and DMA write bytes on counter 3.
    bus_write(8'h24, 32'h0000_0202);
    bus_write(8'h48, 32'h0);
    bus_write(8'h2C, 32'h0000_0008);
    bus_write(8'h58, 32'h0);
    run(150);
    bus_read(8'h24, rd);
    check("rdata_o (sel 1)", rd, 32'h0000_0202);
    bus_read(8'h2C, rd);
    check("rdata_o (sel 3)", rd, 32'h0000_0008);
    check_counter(1);
    check_counter(3);

    // A disabled counter holds and ignores clears.
    bus_write(8'h08, 32'h0);
    bus_read(8'h50, rd);
    held = m_cnt[2][31:0];
    check("rdata_o (counter 2 disabled)", rd, held);
    run(40);
    bus_write(8'h50, 32'h0);
    run(5);
    bus_read(8'h50, rd);
    check("rdata_o (counter 2 held)", rd, held);
    check_counter(2);
    bus_write(8'h08, 32'h1);
    run(30);
    check_counter(2);

    bus_write(8'h40, 32'h0000_dead);
    bus_read(8'h40, rd);
    check("rdata_o (counter 0 cleared)", rd, 32'h0);
    run(20);
    check_counter(0);

    // Metric NONE holds the count.
    bus_write(8'h24, 32'h0000_001F);
    bus_read(8'h48, rd);
    held = m_cnt[1][31:0];
    check("rdata_o (counter 1 to NONE)", rd, held);
    run(40);
    bus_read(8'h48, rd);
    check("rdata_o (counter 1 on NONE)", rd, held);
    check_counter(1);

    run(2);
    $display("All tests passed");
    $finish;
  end

endmodule

/* tb.f */
cluster_periph_pkg.sv
cluster_periph_if.sv
event_sample.sv
reg_decode.sv
perf_counter.sv
wakeup_ctrl.sv
cluster_periph.sv
tb_cluster_periph.sv
